/* logic/alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// datapath widths
`define ALU_DATA_W      64
`define ALU_SCALAR_W    32
`define ALU_OP_W        5
`define ALU_SHIFT_CNT_W 5

// AND keeps the low halfword when the mask select is set
`define ALU_AND_MASK    64'h0000_0000_0000_ffff

// adder second operand per constant select
`define ALU_ADD_IMM_0(op2) (op2)
`define ALU_ADD_IMM_1   32'd2
`define ALU_ADD_IMM_2   32'd4
`define ALU_ADD_IMM_3   32'd0
`define ALU_ADD_IMM_4   32'd6
`define ALU_ADD_IMM_5   32'hffff_fffe
`define ALU_ADD_IMM_6   32'hffff_fffc
`define ALU_ADD_IMM_7   32'd0

`endif

/* logic/alu_pkg.sv */
`include "alu_settings.svh"

package alu_pkg;

    // opcode values follow the x86 execution unit
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_OP_AND   = 0,
        ALU_OP_ADD   = 1,
        ALU_OP_BSF   = 2,
        ALU_OP_PASS2 = 3,
        ALU_OP_PASS1 = 4,
        ALU_OP_NOT   = 9,
        ALU_OP_OR    = 10,
        ALU_OP_PADDW = 11,
        ALU_OP_PADDD = 12,
        ALU_OP_SAR   = 17,
        ALU_OP_SAL   = 18
    } alu_op_e;

    typedef enum logic [1:0] {
        UNIT_SCALAR = 2'd0,
        UNIT_SHIFT  = 2'd1,
        UNIT_SIMD   = 2'd2,
        UNIT_NONE   = 2'd3
    } alu_unit_e;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2,
        SIZE_QWORD = 2'd3
    } alu_size_e;

    typedef struct packed {
        logic cf;
        logic pf;
        logic af;
        logic zf;
        logic sf;
        logic of;
    } alu_flags_t;

    typedef struct packed {
        alu_op_e                op;
        logic [`ALU_DATA_W-1:0] op1;
        logic [`ALU_DATA_W-1:0] op2;
        alu_size_e              size;
        logic                   and_mask_sel;
        logic [2:0]             add_imm_sel;
        logic                   shift_by_one;
    } alu_req_t;

    typedef struct packed {
        alu_req_t  req;
        alu_unit_e unit;
        logic      illegal;
    } alu_uop_t;

    // zf_force marks BSF, which supplies its own ZF
    typedef struct packed {
        logic [`ALU_DATA_W-1:0] data;
        alu_size_e              size;
        logic                   cf;
        logic                   af;
        logic                   of;
        logic                   zf_force;
        logic                   zf_value;
        logic                   cc_inval;
        logic                   illegal;
    } alu_exec_t;

    typedef struct packed {
        logic [`ALU_DATA_W-1:0] data;
        alu_flags_t             flags;
        logic                   cc_inval;
        logic                   illegal;
    } alu_rsp_t;

endpackage

/* logic/alu_pipe_stage.sv */
`timescale 1ns/1ns

module alu_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // accept when empty or when the slot drains this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // stalled output holds
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("pipe stage changed its output while stalled");

endmodule

/* logic/alu_decode.sv */
`timescale 1ns/1ns

module alu_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  alu_pkg::alu_req_t req,
    output logic              uop_valid,
    input  logic              uop_ready,
    output alu_pkg::alu_uop_t uop
);
    import alu_pkg::*;

    alu_uop_t uop_d;

    // opcode to execution unit
    always_comb begin
        uop_d.req     = req;
        uop_d.unit    = UNIT_NONE;
        uop_d.illegal = 1'b0;
        case (req.op)
            ALU_OP_AND, ALU_OP_ADD, ALU_OP_BSF, ALU_OP_PASS2,
            ALU_OP_PASS1, ALU_OP_NOT, ALU_OP_OR: begin
                uop_d.unit = UNIT_SCALAR;
            end
            ALU_OP_SAR, ALU_OP_SAL: begin
                uop_d.unit = UNIT_SHIFT;
            end
            ALU_OP_PADDW, ALU_OP_PADDD: begin
                uop_d.unit = UNIT_SIMD;
            end
            default: begin
                uop_d.illegal = 1'b1;
            end
        endcase
    end

    alu_pipe_stage #(.payload_t(alu_uop_t)) u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (uop_d),
        .out_valid (uop_valid),
        .out_ready (uop_ready),
        .out_data  (uop)
    );

    a_illegal_unit : assert property (
        @(posedge clk) disable iff (!rst_n)
        uop_valid |-> (uop.illegal == (uop.unit == UNIT_NONE))
    ) else $error("micro-op illegal bit does not match its unit");

endmodule

/* logic/alu_scalar_unit.sv */
`timescale 1ns/1ns
`include "alu_settings.svh"

module alu_scalar_unit (
    input  alu_pkg::alu_uop_t       uop,
    output logic [`ALU_DATA_W-1:0]  data,
    output logic                    cf,
    output logic                    af,
    output logic                    of,
    output logic                    zf_force,
    output logic                    zf_value
);
    import alu_pkg::*;

    localparam int SW    = `ALU_SCALAR_W;
    localparam int BSF_W = $clog2(SW);

    logic [`ALU_DATA_W-1:0] and_b;
    logic [SW-1:0]          add_a;
    logic [SW-1:0]          add_b;
    logic [SW-1:0]          add_sum;
    logic                   add_cout;
    logic                   add_af;
    logic                   add_of;
    logic [BSF_W-1:0]       bsf_idx;
    logic                   bsf_zero;

    assign and_b = uop.req.and_mask_sel ? `ALU_AND_MASK : uop.req.op2;

    //////////////////////////////
    // adder
    //////////////////////////////
    assign add_a = uop.req.op1[SW-1:0];

    always_comb begin
        case (uop.req.add_imm_sel)
            3'd0:    add_b = `ALU_ADD_IMM_0(uop.req.op2[SW-1:0]);
            3'd1:    add_b = `ALU_ADD_IMM_1;
            3'd2:    add_b = `ALU_ADD_IMM_2;
            3'd3:    add_b = `ALU_ADD_IMM_3;
            3'd4:    add_b = `ALU_ADD_IMM_4;
            3'd5:    add_b = `ALU_ADD_IMM_5;
            3'd6:    add_b = `ALU_ADD_IMM_6;
            default: add_b = `ALU_ADD_IMM_7;
        endcase
    end

    assign {add_cout, add_sum} = {1'b0, add_a} + {1'b0, add_b};
    // carry into bit 4 recovered from the sum bit
    assign add_af = add_a[4] ^ add_b[4] ^ add_sum[4];
    assign add_of = (add_a[SW-1] == add_b[SW-1]) && (add_sum[SW-1] != add_a[SW-1]);

    //////////////////////////////
    // bit scan forward
    //////////////////////////////
    always_comb begin
        bsf_idx = '0;
        // highest to lowest, so the lowest set bit wins
        for (int i = SW - 1; i >= 0; i--) begin
            if (uop.req.op1[i]) begin
                bsf_idx = BSF_W'(i);
            end
        end
    end

    assign bsf_zero = (uop.req.op1[SW-1:0] == '0);

    always_comb begin
        data     = '0;
        cf       = 1'b0;
        af       = 1'b0;
        of       = 1'b0;
        zf_force = 1'b0;
        zf_value = 1'b0;
        case (uop.req.op)
            ALU_OP_AND:   data = uop.req.op1 & and_b;
            ALU_OP_ADD: begin
                data[SW-1:0] = add_sum;
                cf           = add_cout;
                af           = add_af;
                of           = add_of;
            end
            ALU_OP_BSF: begin
                data[BSF_W-1:0] = bsf_idx;
                zf_force        = 1'b1;
                zf_value        = bsf_zero;
            end
            ALU_OP_PASS2: data = uop.req.op2;
            ALU_OP_PASS1: data = uop.req.op1;
            ALU_OP_NOT:   data = ~uop.req.op1;
            ALU_OP_OR:    data = uop.req.op1 | uop.req.op2;
            default: ;
        endcase
    end

endmodule

/* logic/alu_shift_unit.sv */
`timescale 1ns/1ns
`include "alu_settings.svh"

module alu_shift_unit (
    input  alu_pkg::alu_uop_t      uop,
    output logic [`ALU_DATA_W-1:0] data,
    output logic                   cf,
    output logic                   of,
    output logic                   cc_inval
);
    import alu_pkg::*;

    localparam int SW = `ALU_SCALAR_W;
    localparam int CW = `ALU_SHIFT_CNT_W;

    logic [SW-1:0] a;
    logic [CW-1:0] cnt;
    logic          over;
    logic          is_sar;

    assign a      = uop.req.op1[SW-1:0];
    assign cnt    = uop.req.shift_by_one ? CW'(1) : uop.req.op2[CW-1:0];
    // count bits above the field push the shift out of range
    assign over   = !uop.req.shift_by_one && (uop.req.op2[7:CW] != '0);
    assign is_sar = (uop.req.op == ALU_OP_SAR);

    always_comb begin
        data     = '0;
        cf       = 1'b0;
        of       = 1'b0;
        cc_inval = 1'b0;
        if (over) begin
            // SAL clears everything, SAR saturates to the sign
            if (is_sar) begin
                data[SW-1:0] = {SW{a[SW-1]}};
                cf           = a[SW-1];
            end
        end else if (cnt == '0) begin
            // nothing shifts out, flags stay untouched
            data[SW-1:0] = a;
            cc_inval     = 1'b1;
        end else if (is_sar) begin
            data[SW-1:0] = $signed(a) >>> cnt;
            cf           = a[cnt - 1'b1];
        end else begin
            data[SW-1:0] = a << cnt;
            cf           = a[SW - int'(cnt)];
            of           = (cnt == CW'(1)) && (a[SW-1] ^ a[SW-2]);
        end
    end

endmodule

/* logic/alu_execute.sv */
`timescale 1ns/1ns
`include "alu_settings.svh"

module alu_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               uop_valid,
    output logic               uop_ready,
    input  alu_pkg::alu_uop_t  uop,
    output logic               ex_valid,
    input  logic               ex_ready,
    output alu_pkg::alu_exec_t ex
);
    import alu_pkg::*;

    localparam int DW = `ALU_DATA_W;

    logic [DW-1:0] sc_data;
    logic          sc_cf;
    logic          sc_af;
    logic          sc_of;
    logic          sc_zf_force;
    logic          sc_zf_value;
    logic [DW-1:0] sh_data;
    logic          sh_cf;
    logic          sh_of;
    logic          sh_cc_inval;
    logic [DW-1:0] paddw;
    logic [DW-1:0] paddd;
    alu_exec_t     ex_d;

    alu_scalar_unit u_scalar (
        .uop      (uop),
        .data     (sc_data),
        .cf       (sc_cf),
        .af       (sc_af),
        .of       (sc_of),
        .zf_force (sc_zf_force),
        .zf_value (sc_zf_value)
    );

    alu_shift_unit u_shift (
        .uop      (uop),
        .data     (sh_data),
        .cf       (sh_cf),
        .of       (sh_of),
        .cc_inval (sh_cc_inval)
    );

    //////////////////////////////
    // packed adds with wrapping lanes
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < DW / 16; i++) begin
            paddw[16*i +: 16] = uop.req.op1[16*i +: 16] + uop.req.op2[16*i +: 16];
        end
        for (int i = 0; i < DW / 32; i++) begin
            paddd[32*i +: 32] = uop.req.op1[32*i +: 32] + uop.req.op2[32*i +: 32];
        end
    end

    // unit select
    always_comb begin
        ex_d      = '0;
        ex_d.size = uop.req.size;
        if (uop.illegal) begin
            ex_d.illegal = 1'b1;
        end else begin
            case (uop.unit)
                UNIT_SCALAR: begin
                    ex_d.data     = sc_data;
                    ex_d.cf       = sc_cf;
                    ex_d.af       = sc_af;
                    ex_d.of       = sc_of;
                    ex_d.zf_force = sc_zf_force;
                    ex_d.zf_value = sc_zf_value;
                end
                UNIT_SHIFT: begin
                    ex_d.data     = sh_data;
                    ex_d.cf       = sh_cf;
                    ex_d.of       = sh_of;
                    ex_d.cc_inval = sh_cc_inval;
                end
                UNIT_SIMD: begin
                    ex_d.data = (uop.req.op == ALU_OP_PADDW) ? paddw : paddd;
                end
                default: ;
            endcase
        end
    end

    alu_pipe_stage #(.payload_t(alu_exec_t)) u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (uop_valid),
        .in_ready  (uop_ready),
        .in_data   (ex_d),
        .out_valid (ex_valid),
        .out_ready (ex_ready),
        .out_data  (ex)
    );

endmodule

/* logic/alu_result.sv */
`timescale 1ns/1ns

module alu_result (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ex_valid,
    output logic               ex_ready,
    input  alu_pkg::alu_exec_t ex,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output alu_pkg::alu_rsp_t  rsp
);
    import alu_pkg::*;

    logic     sf;
    alu_rsp_t rsp_d;

    // sign bit by operand size
    always_comb begin
        case (ex.size)
            SIZE_BYTE:  sf = ex.data[7];
            SIZE_WORD:  sf = ex.data[15];
            SIZE_DWORD: sf = ex.data[31];
            default:    sf = ex.data[63];
        endcase
    end

    always_comb begin
        rsp_d.data     = ex.data;
        rsp_d.cc_inval = ex.cc_inval;
        rsp_d.illegal  = ex.illegal;
        rsp_d.flags    = '0;
        if (!ex.illegal) begin
            rsp_d.flags.cf = ex.cf;
            rsp_d.flags.af = ex.af;
            rsp_d.flags.of = ex.of;
            rsp_d.flags.zf = ex.zf_force ? ex.zf_value : (ex.data == '0);
            rsp_d.flags.sf = sf;
            // even parity of the low byte
            rsp_d.flags.pf = ~^ex.data[7:0];
        end
    end

    alu_pipe_stage #(.payload_t(alu_rsp_t)) u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ex_valid),
        .in_ready  (ex_ready),
        .in_data   (rsp_d),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp)
    );

    a_no_inval_on_illegal : assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |-> !(rsp.illegal && rsp.cc_inval)
    ) else $error("cc_inval set on an illegal response");

endmodule

/* logic/alu_top.sv */
`timescale 1ns/1ns

module alu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  alu_pkg::alu_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output alu_pkg::alu_rsp_t rsp
);
    import alu_pkg::*;

    logic      uop_valid;
    logic      uop_ready;
    alu_uop_t  uop;
    logic      ex_valid;
    logic      ex_ready;
    alu_exec_t ex;

    //////////////////////////////
    // three stages
    //////////////////////////////
    alu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .uop_valid (uop_valid),
        .uop_ready (uop_ready),
        .uop       (uop)
    );

    alu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop_valid (uop_valid),
        .uop_ready (uop_ready),
        .uop       (uop),
        .ex_valid  (ex_valid),
        .ex_ready  (ex_ready),
        .ex        (ex)
    );

    alu_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_ready  (ex_ready),
        .ex        (ex),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

/* verification/alu_tests.svh */
`ifndef ALU_TESTS_SVH
`define ALU_TESTS_SVH

// idle state after reset and single request latency
task automatic reset_and_latency();
    alu_req_t r;
    check_val("rsp_valid", 64'd0, 64'(rsp_valid));
    check_val("req_ready", 64'd1, 64'(req_ready));
    r         = make_req(ALU_OP_ADD, 64'h1234, 64'h5678);
    req       = r;
    req_valid = 1'b1;
    exp_q.push_back(ref_model(r));
    @(posedge clk);
    check_val("req_ready", 64'd1, 64'(req_ready));
    @(negedge clk);
    req_valid = 1'b0;
    check_val("rsp_valid", 64'd0, 64'(rsp_valid));
    @(negedge clk);
    check_val("rsp_valid", 64'd0, 64'(rsp_valid));
    // handed over on the third edge after acceptance
    @(negedge clk);
    check_val("rsp_valid", 64'd1, 64'(rsp_valid));
    wait_idle();
endtask

task automatic logic_ops_by_size();
    logic [63:0] a;
    logic [63:0] b;
    for (int s = 0; s < 4; s++) begin
        a = rand64();
        b = rand64();
        send_req(make_req(ALU_OP_AND, a, b, 2'(s)));
        send_req(make_req(ALU_OP_AND, a, b, 2'(s), 1'b1));
        send_req(make_req(ALU_OP_OR, a, b, 2'(s)));
        send_req(make_req(ALU_OP_NOT, a, b, 2'(s)));
        send_req(make_req(ALU_OP_PASS1, a, b, 2'(s)));
        send_req(make_req(ALU_OP_PASS2, a, b, 2'(s)));
        // zero result and set sign bits
        send_req(make_req(ALU_OP_PASS1, 64'd0, b, 2'(s)));
        send_req(make_req(ALU_OP_PASS2, a, 64'h8000_0000_8000_8080, 2'(s)));
        send_req(make_req(ALU_OP_AND, a, 64'd0, 2'(s)));
    end
    wait_idle();
endtask

task automatic add_and_bsf();
    for (int i = 0; i < 8; i++) begin
        send_req(make_req(ALU_OP_ADD, rand64(), rand64(), 2'd2, 1'b0, 3'(i)));
        send_req(make_req(ALU_OP_ADD, 64'h0000_0000_0000_000f, rand64(), 2'd2, 1'b0, 3'(i)));
    end
    // carry out of bit 31, carry out of bit 3, signed overflow
    send_req(make_req(ALU_OP_ADD, 64'hffff_ffff, 64'h1, 2'd2));
    send_req(make_req(ALU_OP_ADD, 64'h0000_000f, 64'h1, 2'd0));
    send_req(make_req(ALU_OP_ADD, 64'h7fff_ffff, 64'h1, 2'd2));
    send_req(make_req(ALU_OP_ADD, 64'h8000_0000, 64'h8000_0000, 2'd2));
    send_req(make_req(ALU_OP_ADD, 64'h1, 64'h0, 2'd2, 1'b0, 3'd5));
    send_req(make_req(ALU_OP_BSF, 64'hffff_ffff_0000_0000, 64'd0, 2'd2));
    send_req(make_req(ALU_OP_BSF, 64'h8000_0000, 64'd0, 2'd2));
    for (int i = 0; i < 8; i++) begin
        send_req(make_req(ALU_OP_BSF, rand64(), rand64(), 2'd2));
    end
    wait_idle();
endtask

task automatic shift_ops();
    logic [63:0] a;
    logic [4:0]  op;
    for (int k = 0; k < 2; k++) begin
        op = (k == 0) ? 5'(ALU_OP_SAL) : 5'(ALU_OP_SAR);
        a  = rand64();
        send_req(make_req(op, a, 64'd1, 2'd2));
        send_req(make_req(op, a, 64'd13, 2'd2));
        send_req(make_req(op, a, 64'd31, 2'd2));
        send_req(make_req(op, a, 64'hff, 2'd2, 1'b0, 3'd0, 1'b1));
        // over range on both signs
        send_req(make_req(op, 64'h8000_1234, 64'h20, 2'd2));
        send_req(make_req(op, 64'h7000_1234, 64'he5, 2'd2));
        send_req(make_req(op, a, 64'h0, 2'd2));
        send_req(make_req(op, 64'h4000_0001, 64'd1, 2'd2));
        send_req(make_req(op, 64'hc000_0001, 64'd1, 2'd2));
    end
    wait_idle();
endtask

task automatic simd_and_illegal();
    for (int i = 0; i < 6; i++) begin
        send_req(make_req(ALU_OP_PADDW, rand64(), rand64(), 2'(i)));
        send_req(make_req(ALU_OP_PADDD, rand64(), rand64(), 2'(i)));
    end
    send_req(make_req(ALU_OP_PADDW, 64'hffff_ffff_ffff_ffff, 64'h0001_0001_0001_0001));
    send_req(make_req(ALU_OP_PADDD, 64'hffff_ffff_ffff_ffff, 64'h0000_0001_0000_0001));
    send_req(make_req(5'd5, rand64(), rand64()));
    send_req(make_req(5'd7, rand64(), rand64()));
    send_req(make_req(5'd13, rand64(), rand64()));
    send_req(make_req(5'd31, rand64(), rand64(), 2'd0, 1'b1, 3'd3, 1'b1));
    wait_idle();
endtask

// mixed burst while the response side stalls at random
task automatic burst_under_stall();
    alu_req_t    burst [BURST_LEN];
    logic [4:0]  ops [13];
    logic [31:0] pick;
    logic [31:0] coin;
    logic [63:0] b;
    ops = '{5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd9, 5'd10, 5'd11, 5'd12, 5'd17, 5'd18,
            5'd5, 5'd13};
    for (int i = 0; i < BURST_LEN; i++) begin
        pick = lcg_next();
        b    = rand64();
        if (pick[0]) begin
            b[7:5] = 3'd0;
        end
        burst[i] = make_req(ops[int'(pick[31:16]) % 13], rand64(), b, pick[2:1],
                            pick[3], pick[6:4], pick[7] & pick[8]);
    end
    burst_done = 1'b0;
    fork
        begin
            for (int i = 0; i < BURST_LEN; i++) begin
                send_req(burst[i]);
            end
            burst_done = 1'b1;
        end
        begin
            while (!burst_done || exp_q.size() != 0) begin
                @(negedge clk);
                coin      = lcg_next();
                rsp_ready = coin[20];
            end
            rsp_ready = 1'b1;
        end
    join
    wait_idle();
endtask

`endif

/* verification/alu_tb.sv */
`timescale 1ns/1ns

module alu_tb;
    import alu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 2000;
    localparam int BURST_LEN    = 120;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    logic     req_ready;
    alu_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    alu_rsp_t rsp;

    alu_rsp_t    exp_q[$];
    logic [31:0] lcg_state;
    logic        held_valid;
    alu_rsp_t    held_rsp;
    logic        burst_done;

    alu_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h got %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_rsp(input string tag, input alu_rsp_t e, input alu_rsp_t g);
        check_val({tag, ".data"}, e.data, g.data);
        check_val({tag, ".cf"}, 64'(e.flags.cf), 64'(g.flags.cf));
        check_val({tag, ".pf"}, 64'(e.flags.pf), 64'(g.flags.pf));
        check_val({tag, ".af"}, 64'(e.flags.af), 64'(g.flags.af));
        check_val({tag, ".zf"}, 64'(e.flags.zf), 64'(g.flags.zf));
        check_val({tag, ".sf"}, 64'(e.flags.sf), 64'(g.flags.sf));
        check_val({tag, ".of"}, 64'(e.flags.of), 64'(g.flags.of));
        check_val({tag, ".cc_inval"}, 64'(e.cc_inval), 64'(g.cc_inval));
        check_val({tag, ".illegal"}, 64'(e.illegal), 64'(g.illegal));
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic alu_rsp_t ref_model(input alu_req_t r);
        alu_rsp_t    m;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        logic [32:0] wide;
        logic [4:0]  nib;
        logic        zf_given;
        logic        zf_bsf;
        logic        over;
        int          cnt;
        int          k;
        m        = '0;
        zf_given = 1'b0;
        zf_bsf   = 1'b0;
        a        = r.op1[31:0];
        case (r.op)
            ALU_OP_AND:   m.data = r.op1 & (r.and_mask_sel ? 64'h0000_0000_0000_ffff : r.op2);
            ALU_OP_OR:    m.data = r.op1 | r.op2;
            ALU_OP_NOT:   m.data = ~r.op1;
            ALU_OP_PASS1: m.data = r.op1;
            ALU_OP_PASS2: m.data = r.op2;
            ALU_OP_ADD: begin
                case (r.add_imm_sel)
                    3'd0:    b = r.op2[31:0];
                    3'd1:    b = 32'd2;
                    3'd2:    b = 32'd4;
                    3'd4:    b = 32'd6;
                    3'd5:    b = -32'sd2;
                    3'd6:    b = -32'sd4;
                    default: b = 32'd0;
                endcase
                wide          = {1'b0, a} + {1'b0, b};
                nib           = {1'b0, a[3:0]} + {1'b0, b[3:0]};
                m.data        = {32'd0, wide[31:0]};
                m.flags.cf    = wide[32];
                m.flags.af    = nib[4];
                m.flags.of    = (a[31] == b[31]) && (wide[31] != a[31]);
            end
            ALU_OP_BSF: begin
                k = 0;
                while (k < 32 && !a[k]) begin
                    k++;
                end
                zf_given = 1'b1;
                zf_bsf   = (k == 32);
                m.data   = (k == 32) ? 64'd0 : 64'(k);
            end
            ALU_OP_PADDW: begin
                for (int i = 0; i < 4; i++) begin
                    m.data[16*i +: 16] = r.op1[16*i +: 16] + r.op2[16*i +: 16];
                end
            end
            ALU_OP_PADDD: begin
                for (int i = 0; i < 2; i++) begin
                    m.data[32*i +: 32] = r.op1[32*i +: 32] + r.op2[32*i +: 32];
                end
            end
            ALU_OP_SAR, ALU_OP_SAL: begin
                over = !r.shift_by_one && (r.op2[7:5] != 3'd0);
                cnt  = r.shift_by_one ? 1 : int'(r.op2[4:0]);
                if (over) begin
                    if (r.op == ALU_OP_SAR) begin
                        m.data     = {32'd0, {32{a[31]}}};
                        m.flags.cf = a[31];
                    end
                end else if (cnt == 0) begin
                    m.data     = {32'd0, a};
                    m.cc_inval = 1'b1;
                end else begin
                    s = a;
                    // one bit per step so the last bit out ends in CF
                    for (int i = 0; i < cnt; i++) begin
                        if (r.op == ALU_OP_SAR) begin
                            m.flags.cf = s[0];
                            s          = {s[31], s[31:1]};
                        end else begin
                            m.flags.cf = s[31];
                            s          = {s[30:0], 1'b0};
                        end
                    end
                    m.data = {32'd0, s};
                    if (cnt == 1 && r.op == ALU_OP_SAL) begin
                        m.flags.of = a[31] ^ a[30];
                    end
                end
            end
            default: m.illegal = 1'b1;
        endcase
        if (!m.illegal) begin
            m.flags.zf = zf_given ? zf_bsf : (m.data == 64'd0);
            case (r.size)
                SIZE_BYTE:  m.flags.sf = m.data[7];
                SIZE_WORD:  m.flags.sf = m.data[15];
                SIZE_DWORD: m.flags.sf = m.data[31];
                default:    m.flags.sf = m.data[63];
            endcase
            m.flags.pf = ($countones(m.data[7:0]) % 2) == 0;
        end
        return m;
    endfunction

    function automatic alu_req_t make_req(
        input logic [4:0]  op,
        input logic [63:0] op1,
        input logic [63:0] op2,
        input logic [1:0]  size = 2'd3,
        input logic        mask = 1'b0,
        input logic [2:0]  imm  = 3'd0,
        input logic        sbo  = 1'b0
    );
        alu_req_t r;
        r.op           = alu_op_e'(op);
        r.op1          = op1;
        r.op2          = op2;
        r.size         = alu_size_e'(size);
        r.and_mask_sel = mask;
        r.add_imm_sel  = imm;
        r.shift_by_one = sbo;
        return r;
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_req(input alu_req_t r);
        req       = r;
        req_valid = 1'b1;
        exp_q.push_back(ref_model(r));
        do begin
            @(posedge clk);
        end while (!req_ready);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // response monitor with stall hold check
    always @(posedge clk) begin
        alu_rsp_t e;
        if (rst_n) begin
            if (held_valid) begin
                check_val("held rsp_valid", 64'd1, 64'(rsp_valid));
                compare_rsp("held rsp", held_rsp, rsp);
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a response arrived with no request outstanding");
                    $display("Testbench failed");
                    $fatal(1, "unexpected response");
                end
                e = exp_q.pop_front();
                compare_rsp("rsp", e, rsp);
            end
            held_valid = rsp_valid && !rsp_ready;
            held_rsp   = rsp;
        end
    end

    `include "alu_tests.svh"

    //////////////////////////////
    // sequence and watchdog
    //////////////////////////////
    initial begin
        #((RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish within their cycle budget");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b1;
        held_valid = 1'b0;
        burst_done = 1'b0;
        lcg_state  = 32'h2c8fd087;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_and_latency();
        logic_ops_by_size();
        add_and_bsf();
        shift_ops();
        simd_and_illegal();
        burst_under_stall();
        // a duplicated response still in the pipeline reaches the monitor here
        repeat (4) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
+incdir+verification
logic/alu_pkg.sv
logic/alu_pipe_stage.sv
logic/alu_decode.sv
logic/alu_scalar_unit.sv
logic/alu_shift_unit.sv
logic/alu_execute.sv
logic/alu_result.sv
logic/alu_top.sv
verification/alu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module alu_tb -o alu_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/alu_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Testbench failed" "$SIM_LOG"; then
    echo "simulation reported failure, see $SIM_LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
